// ==== design/dma_cfg.svh ====
// DMA build parameters
`ifndef DMA_CFG_SVH
`define DMA_CFG_SVH

// transfer FIFO entries, power of two
`define DMA_FIFO_DEPTH 8

// byte address width of both master ports
`define DMA_AW 32

`define DMA_MEM_WORDS 1024  // testbench memory size in words

`endif

// ==== design/dma_regs_pkg.sv ====
// DMA register map
`default_nettype none

package dma_regs_pkg;

   // register index, slave address bits 4..2
   typedef enum logic [2:0] {
      REG_CCR     = 3'd0,
      REG_CSR     = 3'd1,
      REG_DAR     = 3'd2,
      REG_NDAR    = 3'd3,
      REG_SG_CTRL = 3'd4,
      REG_SG_SRC  = 3'd5,
      REG_SG_DST  = 3'd6,
      REG_RSVD    = 3'd7   // reads zero
   } reg_idx_e;

   localparam int CCR_RESUME  = 0;
   localparam int CCR_ENABLE  = 1;
   localparam int CCR_INT_CLR = 2;  // write one to drop int_o

   localparam int CSR_INT        = 0;
   localparam int CSR_BUSY       = 1;
   localparam int CSR_NDAR_DIRTY = 2;

endpackage

`default_nettype wire

// ==== design/dma_desc_pkg.sv ====
// DMA descriptor and datapath types
`default_nettype none

package dma_desc_pkg;

   // word offset inside a four-word descriptor
   typedef enum logic [1:0] {
      DW_CTRL,
      DW_SRC,
      DW_DST,
      DW_NEXT
   } desc_word_e;

   // control word layout
   localparam int DESC_EOL_BIT = 31;
   localparam int DESC_IRQ_BIT = 30;
   localparam int DESC_LEN_MSB = 15;  // length in words, bits 15..0

   // tag carried with every FIFO entry
   typedef enum logic [1:0] {
      ENT_DST,       // payload is the destination address
      ENT_DATA,
      ENT_LAST,
      ENT_LAST_IRQ
   } ent_kind_e;

   typedef enum logic [2:0] {RD_IDLE, RD_DESC, RD_PUSH_DST, RD_DATA, RD_NEXT} rd_state_e;
   typedef enum logic {WR_IDLE, WR_BUS} wr_state_e;

endpackage

`default_nettype wire

// ==== design/dma_regs.sv ====
// DMA slave register block
`timescale 1ns/1ps
`default_nettype none

module dma_regs
   import dma_regs_pkg::*;
(
   input  wire         wb_clk_i,
   input  wire         wb_rst_i,
   input  wire         wbs_cyc_i,
   input  wire         wbs_stb_i,
   input  wire         wbs_we_i,
   input  wire  [3:0]  wbs_sel_i,
   input  wire  [31:0] wbs_adr_i,
   input  wire  [31:0] wbs_dat_i,
   output logic [31:0] wbs_dat_o,
   output logic        wbs_ack_o,
   output logic        wbs_err_o,
   input  wire         rd_busy_i,
   input  wire         wr_busy_i,
   input  wire         fifo_busy_i,
   input  wire         ndar_load_i,
   input  wire         desc_done_i,
   input  wire         desc_irq_i,
   input  wire  [31:0] dar_i,
   input  wire  [31:0] sg_ctrl_i,
   input  wire  [31:0] sg_src_i,
   input  wire  [31:0] sg_dst_i,
   output logic        enable_o,
   output logic        resume_o,
   output logic [31:0] ndar_o,
   output logic        ndar_dirty_o,
   output logic        int_o
);

   logic     access;        // new strobe, not answered yet
   logic     valid_access;
   logic     ccr_we;
   logic     ndar_we;
   reg_idx_e idx;

   assign access       = wbs_cyc_i & wbs_stb_i & ~wbs_ack_o & ~wbs_err_o;
   assign valid_access = access & (wbs_sel_i == 4'b1111);  // full words only
   assign idx          = reg_idx_e'(wbs_adr_i[4:2]);
   assign ccr_we       = valid_access & wbs_we_i & (idx == REG_CCR);
   assign ndar_we      = valid_access & wbs_we_i & (idx == REG_NDAR) & ~enable_o;

   always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
      if (wb_rst_i) begin
         wbs_ack_o <= 1'b0;
         wbs_err_o <= 1'b0;
      end else begin
         wbs_ack_o <= valid_access;
         wbs_err_o <= access & ~valid_access;
      end
   end

   always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
      if (wb_rst_i) begin
         enable_o     <= 1'b0;
         resume_o     <= 1'b0;
         ndar_dirty_o <= 1'b0;
         int_o        <= 1'b0;
      end else begin
         if (ccr_we) begin
            enable_o <= wbs_dat_i[CCR_ENABLE];
            resume_o <= wbs_dat_i[CCR_RESUME];
         end else if (ndar_load_i) begin
            resume_o <= 1'b0;              // start consumed
         end
         if (ndar_we)
            ndar_dirty_o <= 1'b1;
         else if (ndar_load_i)
            ndar_dirty_o <= 1'b0;
         // a finishing descriptor wins over a clear in the same cycle
         if (desc_done_i && desc_irq_i)
            int_o <= 1'b1;
         else if (ccr_we && wbs_dat_i[CCR_INT_CLR])
            int_o <= 1'b0;
      end
   end

   always_ff @(posedge wb_clk_i) begin
      if (ndar_we)
         ndar_o <= wbs_dat_i;
   end

   always_comb begin
      wbs_dat_o = '0;
      case (idx)
         REG_CCR: begin
            wbs_dat_o[CCR_RESUME] = resume_o;
            wbs_dat_o[CCR_ENABLE] = enable_o;
         end
         REG_CSR: begin
            wbs_dat_o[CSR_INT]        = int_o;
            wbs_dat_o[CSR_BUSY]       = rd_busy_i | wr_busy_i | fifo_busy_i;
            wbs_dat_o[CSR_NDAR_DIRTY] = ndar_dirty_o;
         end
         REG_DAR:     wbs_dat_o = dar_i;
         REG_NDAR:    wbs_dat_o = ndar_o;
         REG_SG_CTRL: wbs_dat_o = sg_ctrl_i;
         REG_SG_SRC:  wbs_dat_o = sg_src_i;
         REG_SG_DST:  wbs_dat_o = sg_dst_i;
         default:     wbs_dat_o = '0;
      endcase
   end

endmodule

`default_nettype wire

// ==== design/sg_reader.sv ====
// descriptor chain reader
`timescale 1ns/1ps
`default_nettype none
`include "dma_cfg.svh"

module sg_reader
   import dma_desc_pkg::*;
(
   input  wire                wb_clk_i,
   input  wire                wb_rst_i,
   input  wire                enable_i,
   input  wire                resume_i,
   input  wire  [31:0]        ndar_i,
   input  wire                ndar_dirty_i,
   output logic               ndar_load_o,
   output logic               wbma_cyc_o,
   output logic               wbma_stb_o,
   output logic [`DMA_AW-1:0] wbma_adr_o,
   input  wire  [31:0]        wbma_dat_i,
   input  wire                wbma_ack_i,
   output logic               push_o,
   output ent_kind_e          push_kind_o,
   output logic [31:0]        push_data_o,
   input  wire                full_i,
   output logic [31:0]        dar_o,
   output logic [31:0]        sg_ctrl_o,
   output logic [31:0]        sg_src_o,
   output logic [31:0]        sg_dst_o,
   output logic               busy_o
);

   localparam int LW = DESC_LEN_MSB + 1;

   rd_state_e          state;
   desc_word_e         widx;     // descriptor word in flight
   logic [31:0]        next_q;   // link of the current descriptor
   logic [`DMA_AW-1:0] rptr;     // source word pointer
   logic [LW-1:0]      remain;
   logic               cyc_q;
   logic               start;
   logic               follow;
   logic               bus_ack;
   logic               last_word;

   assign start       = (state == RD_IDLE) & enable_i & (ndar_dirty_i | resume_i);
   assign follow      = (state == RD_NEXT) & ~sg_ctrl_o[DESC_EOL_BIT] & enable_i;
   assign bus_ack     = cyc_q & wbma_ack_i;
   assign last_word   = (remain == LW'(1));
   assign ndar_load_o = start;  // tells the regs a start was taken
   assign wbma_cyc_o  = cyc_q;
   assign wbma_stb_o  = cyc_q;
   assign busy_o      = (state != RD_IDLE);
   assign wbma_adr_o  = (state == RD_DESC) ? dar_o + {widx, 2'b00} : rptr;

   always_comb begin
      push_o      = 1'b0;
      push_kind_o = ENT_DST;
      push_data_o = sg_dst_o;
      if (state == RD_PUSH_DST) begin
         push_o = ~full_i;
      end else if (state == RD_DATA) begin
         push_o      = bus_ack;   // room was checked before the read
         push_data_o = wbma_dat_i;
         if (!last_word)
            push_kind_o = ENT_DATA;
         else if (sg_ctrl_o[DESC_IRQ_BIT])
            push_kind_o = ENT_LAST_IRQ;
         else
            push_kind_o = ENT_LAST;
      end
   end

   always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
      if (wb_rst_i) begin
         state  <= RD_IDLE;
         widx   <= DW_CTRL;
         remain <= '0;
         cyc_q  <= 1'b0;
      end else begin
         case (state)
            RD_IDLE: begin
               if (start) begin
                  widx  <= DW_CTRL;
                  state <= RD_DESC;
               end
            end
            RD_DESC: begin
               if (!cyc_q) begin
                  cyc_q <= 1'b1;
               end else if (wbma_ack_i) begin
                  cyc_q <= 1'b0;
                  if (widx == DW_NEXT)
                     state <= RD_PUSH_DST;
                  else
                     widx <= desc_word_e'(widx + 2'd1);
               end
            end
            RD_PUSH_DST: begin
               if (!full_i) begin
                  remain <= sg_ctrl_o[DESC_LEN_MSB:0];
                  state  <= (sg_ctrl_o[DESC_LEN_MSB:0] == '0) ? RD_NEXT : RD_DATA;
               end
            end
            RD_DATA: begin
               if (!cyc_q) begin
                  cyc_q <= ~full_i;            // hold off while FIFO is full
               end else if (wbma_ack_i) begin
                  cyc_q  <= 1'b0;
                  remain <= remain - 1'b1;
                  if (last_word)
                     state <= RD_NEXT;
               end
            end
            RD_NEXT: begin
               widx  <= DW_CTRL;
               state <= follow ? RD_DESC : RD_IDLE;
            end
            default: state <= RD_IDLE;
         endcase
      end
   end

   always_ff @(posedge wb_clk_i) begin
      if (start)
         dar_o <= ndar_dirty_i ? ndar_i : next_q;
      else if (follow)
         dar_o <= next_q;
      if (state == RD_DESC && bus_ack) begin
         case (widx)
            DW_CTRL: sg_ctrl_o <= wbma_dat_i;
            DW_SRC:  sg_src_o  <= wbma_dat_i;
            DW_DST:  sg_dst_o  <= wbma_dat_i;
            default: next_q    <= wbma_dat_i;
         endcase
      end
      if (state == RD_PUSH_DST)
         rptr <= sg_src_o;
      else if (state == RD_DATA && bus_ack)
         rptr <= rptr + `DMA_AW'(4);
   end

endmodule

`default_nettype wire

// ==== design/xfer_fifo.sv ====
// tagged transfer FIFO
`timescale 1ns/1ps
`default_nettype none
`include "dma_cfg.svh"

module xfer_fifo
   import dma_desc_pkg::*;
(
   input  wire              wb_clk_i,
   input  wire              wb_rst_i,
   input  wire              push_i,
   input  wire  ent_kind_e  push_kind_i,
   input  wire  [31:0]      push_data_i,
   input  wire              pop_i,
   output ent_kind_e        head_kind_o,
   output logic [31:0]      head_data_o,
   output logic             full_o,
   output logic             empty_o
);

   localparam int DEPTH = `DMA_FIFO_DEPTH;
   localparam int PW    = $clog2(DEPTH);  // pointers wrap on their own

   ent_kind_e     kind_mem [DEPTH];
   logic [31:0]   data_mem [DEPTH];
   logic [PW-1:0] wr_ptr;
   logic [PW-1:0] rd_ptr;
   logic [PW:0]   count;
   logic          do_push;
   logic          do_pop;

   assign full_o      = (count == (PW+1)'(DEPTH));
   assign empty_o     = (count == '0);
   assign do_push     = push_i & ~full_o;
   assign do_pop      = pop_i & ~empty_o;
   assign head_kind_o = kind_mem[rd_ptr];  // show-ahead
   assign head_data_o = data_mem[rd_ptr];

   always_ff @(posedge wb_clk_i) begin
      if (do_push) begin
         kind_mem[wr_ptr] <= push_kind_i;
         data_mem[wr_ptr] <= push_data_i;
      end
   end

   always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
      if (wb_rst_i) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_push)
            wr_ptr <= wr_ptr + 1'b1;
         if (do_pop)
            rd_ptr <= rd_ptr + 1'b1;
         case ({do_push, do_pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;   // idle or both
         endcase
      end
   end

endmodule

`default_nettype wire

// ==== design/sg_writer.sv ====
// destination writer
`timescale 1ns/1ps
`default_nettype none
`include "dma_cfg.svh"

module sg_writer
   import dma_desc_pkg::*;
(
   input  wire                wb_clk_i,
   input  wire                wb_rst_i,
   input  wire  ent_kind_e    head_kind_i,
   input  wire  [31:0]        head_data_i,
   input  wire                empty_i,
   output logic               pop_o,
   output logic               wbmb_cyc_o,
   output logic               wbmb_stb_o,
   output logic               wbmb_we_o,
   output logic [`DMA_AW-1:0] wbmb_adr_o,
   output logic [31:0]        wbmb_dat_o,
   input  wire                wbmb_ack_i,
   output logic               desc_done_o,
   output logic               desc_irq_o,
   output logic               busy_o
);

   wr_state_e          state;
   logic [`DMA_AW-1:0] wptr;      // next destination address
   logic               wr_ack;
   logic               take_dst;

   assign take_dst    = (state == WR_IDLE) & ~empty_i & (head_kind_i == ENT_DST);
   assign wr_ack      = (state == WR_BUS) & wbmb_ack_i;
   assign pop_o       = take_dst | wr_ack;   // data stays at the head until acked
   assign desc_done_o = wr_ack & (head_kind_i inside {ENT_LAST, ENT_LAST_IRQ});
   assign desc_irq_o  = desc_done_o & (head_kind_i == ENT_LAST_IRQ);
   assign wbmb_cyc_o  = (state == WR_BUS);
   assign wbmb_stb_o  = (state == WR_BUS);
   assign wbmb_we_o   = (state == WR_BUS);
   assign wbmb_adr_o  = wptr;
   assign wbmb_dat_o  = head_data_i;
   assign busy_o      = (state == WR_BUS);

   always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
      if (wb_rst_i)
         state <= WR_IDLE;
      else if (state == WR_IDLE && !empty_i && head_kind_i != ENT_DST)
         state <= WR_BUS;
      else if (wr_ack)
         state <= WR_IDLE;
   end

   always_ff @(posedge wb_clk_i) begin
      if (take_dst)
         wptr <= head_data_i;
      else if (wr_ack)
         wptr <= wptr + `DMA_AW'(4);
   end

endmodule

`default_nettype wire

// ==== design/dma_sg_top.sv ====
// scatter-gather DMA top level
`timescale 1ns/1ps
`default_nettype none
`include "dma_cfg.svh"

module dma_sg_top
   import dma_desc_pkg::*;
(
   input  wire                wb_clk_i,
   input  wire                wb_rst_i,
   input  wire                wbs_cyc_i,
   input  wire                wbs_stb_i,
   input  wire                wbs_we_i,
   input  wire  [3:0]         wbs_sel_i,
   input  wire  [31:0]        wbs_adr_i,
   input  wire  [31:0]        wbs_dat_i,
   output logic [31:0]        wbs_dat_o,
   output logic               wbs_ack_o,
   output logic               wbs_err_o,
   output logic               wbma_cyc_o,
   output logic               wbma_stb_o,
   output logic [`DMA_AW-1:0] wbma_adr_o,
   input  wire  [31:0]        wbma_dat_i,
   input  wire                wbma_ack_i,
   output logic               wbmb_cyc_o,
   output logic               wbmb_stb_o,
   output logic               wbmb_we_o,
   output logic [`DMA_AW-1:0] wbmb_adr_o,
   output logic [31:0]        wbmb_dat_o,
   input  wire                wbmb_ack_i,
   output logic               int_o
);

   logic        enable, resume, ndar_dirty, ndar_load;
   logic [31:0] ndar, dar, sg_ctrl, sg_src, sg_dst;
   logic        push, full, pop, empty;
   ent_kind_e   push_kind, head_kind;
   logic [31:0] push_data, head_data;
   logic        rd_busy, wr_busy, desc_done, desc_irq;

   dma_regs dma_regs_inst (
      .wb_clk_i, .wb_rst_i,
      .wbs_cyc_i, .wbs_stb_i, .wbs_we_i, .wbs_sel_i, .wbs_adr_i, .wbs_dat_i,
      .wbs_dat_o, .wbs_ack_o, .wbs_err_o,
      .rd_busy_i(rd_busy), .wr_busy_i(wr_busy), .fifo_busy_i(~empty),
      .ndar_load_i(ndar_load), .desc_done_i(desc_done), .desc_irq_i(desc_irq),
      .dar_i(dar), .sg_ctrl_i(sg_ctrl), .sg_src_i(sg_src), .sg_dst_i(sg_dst),
      .enable_o(enable), .resume_o(resume), .ndar_o(ndar),
      .ndar_dirty_o(ndar_dirty), .int_o
   );

   sg_reader sg_reader_inst (
      .wb_clk_i, .wb_rst_i,
      .enable_i(enable), .resume_i(resume), .ndar_i(ndar),
      .ndar_dirty_i(ndar_dirty), .ndar_load_o(ndar_load),
      .wbma_cyc_o, .wbma_stb_o, .wbma_adr_o, .wbma_dat_i, .wbma_ack_i,
      .push_o(push), .push_kind_o(push_kind), .push_data_o(push_data), .full_i(full),
      .dar_o(dar), .sg_ctrl_o(sg_ctrl), .sg_src_o(sg_src), .sg_dst_o(sg_dst),
      .busy_o(rd_busy)
   );

   xfer_fifo xfer_fifo_inst (
      .wb_clk_i, .wb_rst_i,
      .push_i(push), .push_kind_i(push_kind), .push_data_i(push_data),
      .pop_i(pop), .head_kind_o(head_kind), .head_data_o(head_data),
      .full_o(full), .empty_o(empty)
   );

   sg_writer sg_writer_inst (
      .wb_clk_i, .wb_rst_i,
      .head_kind_i(head_kind), .head_data_i(head_data), .empty_i(empty), .pop_o(pop),
      .wbmb_cyc_o, .wbmb_stb_o, .wbmb_we_o, .wbmb_adr_o, .wbmb_dat_o, .wbmb_ack_i,
      .desc_done_o(desc_done), .desc_irq_o(desc_irq), .busy_o(wr_busy)
   );

endmodule

`default_nettype wire

// ==== verif/tb_mem.sv ====
// dual-port Wishbone memory model
`timescale 1ns/1ps
`default_nettype none
`include "dma_cfg.svh"

module tb_mem #(
   parameter int          WORDS = `DMA_MEM_WORDS,
   parameter logic [31:0] SEED  = 32'hcc7a6620
) (
   input  wire         wb_clk_i,
   input  wire         wb_rst_i,
   input  wire         a_cyc_i,
   input  wire         a_stb_i,
   input  wire  [31:0] a_adr_i,
   output logic [31:0] a_dat_o,
   output logic        a_ack_o,
   input  wire         b_cyc_i,
   input  wire         b_stb_i,
   input  wire         b_we_i,
   input  wire  [31:0] b_adr_i,
   input  wire  [31:0] b_dat_i,
   output logic        b_ack_o,
   input  wire         b_slow_i,     // port B always waits the longest
   output logic        dup_write_o
);

   localparam int IW = $clog2(WORDS);

   logic [31:0]   mem [WORDS];
   logic          written [WORDS];   // set by the first port B write
   integer        seed_a;
   integer        seed_b;
   logic [31:0]   rnd_a;
   logic [31:0]   rnd_b;
   logic [1:0]    cnt_a;
   logic [1:0]    cnt_b;
   logic [1:0]    left_a;
   logic [1:0]    left_b;
   logic          wait_a;
   logic          wait_b;
   logic [IW-1:0] idx_a;
   logic [IW-1:0] idx_b;

   assign idx_a = a_adr_i[IW+1:2];
   assign idx_b = b_adr_i[IW+1:2];

   initial begin
      seed_a = SEED;
      seed_b = SEED ^ 32'h0000_5a5a;
      for (int i = 0; i < WORDS; i++)
         written[i] = 1'b0;
   end

   // port A, reads only
   always @(posedge wb_clk_i or posedge wb_rst_i) begin
      if (wb_rst_i) begin
         a_ack_o <= 1'b0;
         wait_a  <= 1'b0;
         cnt_a   <= '0;
      end else begin
         a_ack_o <= 1'b0;
         if (a_cyc_i && a_stb_i && !a_ack_o) begin
            if (!wait_a)
               rnd_a = $random(seed_a);       // new delay per cycle
            left_a = wait_a ? cnt_a : rnd_a[1:0];
            if (left_a == 2'd0) begin
               a_ack_o <= 1'b1;
               a_dat_o <= mem[idx_a];
               wait_a  <= 1'b0;
            end else begin
               cnt_a  <= left_a - 1'b1;
               wait_a <= 1'b1;
            end
         end
      end
   end

   // port B, writes
   always @(posedge wb_clk_i or posedge wb_rst_i) begin
      if (wb_rst_i) begin
         b_ack_o     <= 1'b0;
         wait_b      <= 1'b0;
         cnt_b       <= '0;
         dup_write_o <= 1'b0;
      end else begin
         b_ack_o <= 1'b0;
         if (b_cyc_i && b_stb_i && !b_ack_o) begin
            if (!wait_b)
               rnd_b = $random(seed_b);
            left_b = wait_b ? cnt_b : (b_slow_i ? 2'd3 : rnd_b[1:0]);
            if (left_b == 2'd0) begin
               b_ack_o <= 1'b1;
               wait_b  <= 1'b0;
               if (b_we_i) begin
                  if (written[idx_b])
                     dup_write_o <= 1'b1;
                  written[idx_b] <= 1'b1;
                  mem[idx_b]     <= b_dat_i;
               end
            end else begin
               cnt_b  <= left_b - 1'b1;
               wait_b <= 1'b1;
            end
         end
      end
   end

endmodule

`default_nettype wire

// ==== verif/dma_sg_tb.sv ====
// scatter-gather DMA testbench
`timescale 1ns/1ps
`default_nettype none
`include "dma_cfg.svh"

module dma_sg_tb
   import dma_regs_pkg::*, dma_desc_pkg::*;
();

   // memory layout in word indices
   localparam int SINGLE_DESC = 0;
   localparam int SINGLE_LEN  = 6;
   localparam int CHAIN_DESC  = 4;    // three descriptors four words apart
   localparam int CHAIN_MAX   = 16;
   localparam int BP_DESC     = 16;
   localparam int BP_LEN      = 20;
   localparam int PAUSE_DESC  = 20;
   localparam int PAUSE_LEN   = 12;
   localparam int MOVED_WORDS = SINGLE_LEN + 3 * CHAIN_MAX + BP_LEN + 2 * PAUSE_LEN;
   localparam int DESC_READS  = 4 * 7;
   localparam int WORD_CYCLES = 12;   // worst read plus write of one word
   localparam int WATCHDOG_NS = 10 * ((MOVED_WORDS + DESC_READS) * WORD_CYCLES + 3000);

   logic        wb_clk;
   logic        wb_rst;
   logic        wbs_cyc;
   logic        wbs_stb;
   logic        wbs_we;
   logic [3:0]  wbs_sel;
   logic [31:0] wbs_adr;
   logic [31:0] wbs_dat_w;
   logic [31:0] wbs_dat_r;
   logic        wbs_ack;
   logic        wbs_err;
   logic        wbma_cyc;
   logic        wbma_stb;
   logic [`DMA_AW-1:0] wbma_adr;
   logic [31:0] wbma_dat;
   logic        wbma_ack;
   logic        wbmb_cyc;
   logic        wbmb_stb;
   logic        wbmb_we;
   logic [`DMA_AW-1:0] wbmb_adr;
   logic [31:0] wbmb_dat;
   logic        wbmb_ack;
   logic        irq;
   logic        b_slow;
   logic        dup_write;
   logic        int_prev;
   int          int_rises = 0;
   int          chain_len [3];
   integer      seed = 32'hcc7a6620;

   dma_sg_top dma_sg_top_inst (
      .wb_clk_i(wb_clk), .wb_rst_i(wb_rst),
      .wbs_cyc_i(wbs_cyc), .wbs_stb_i(wbs_stb), .wbs_we_i(wbs_we), .wbs_sel_i(wbs_sel),
      .wbs_adr_i(wbs_adr), .wbs_dat_i(wbs_dat_w), .wbs_dat_o(wbs_dat_r),
      .wbs_ack_o(wbs_ack), .wbs_err_o(wbs_err),
      .wbma_cyc_o(wbma_cyc), .wbma_stb_o(wbma_stb), .wbma_adr_o(wbma_adr),
      .wbma_dat_i(wbma_dat), .wbma_ack_i(wbma_ack),
      .wbmb_cyc_o(wbmb_cyc), .wbmb_stb_o(wbmb_stb), .wbmb_we_o(wbmb_we),
      .wbmb_adr_o(wbmb_adr), .wbmb_dat_o(wbmb_dat), .wbmb_ack_i(wbmb_ack),
      .int_o(irq)
   );

   tb_mem #(.SEED(32'hcc7a6620)) tb_mem_inst (
      .wb_clk_i(wb_clk), .wb_rst_i(wb_rst),
      .a_cyc_i(wbma_cyc), .a_stb_i(wbma_stb), .a_adr_i(wbma_adr),
      .a_dat_o(wbma_dat), .a_ack_o(wbma_ack),
      .b_cyc_i(wbmb_cyc), .b_stb_i(wbmb_stb), .b_we_i(wbmb_we), .b_adr_i(wbmb_adr),
      .b_dat_i(wbmb_dat), .b_ack_o(wbmb_ack),
      .b_slow_i(b_slow), .dup_write_o(dup_write)
   );

   initial wb_clk = 1'b0;
   always #5 wb_clk = ~wb_clk;

   always @(posedge wb_clk) begin
      if (irq && !int_prev)
         int_rises <= int_rises + 1;
      int_prev <= irq;
   end

   task automatic report_mismatch(input string name, input logic [31:0] exp,
                                  input logic [31:0] act);
      $display("Fail at %0t ns: %s expected %h, got %h", $time, name, exp, act);
      $display("SOME TESTS FAILED");
      $fatal(1, "run stopped at first error");
   endtask

   task automatic report_problem(input string what);
      $display("Error at %0t ns: %s", $time, what);
      $display("SOME TESTS FAILED");
      $fatal(1, "run stopped at first error");
   endtask

   task automatic expect_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
      assert (act === exp) else report_mismatch(name, exp, act);
   endtask

   // slave ack lasts one cycle
   assert property (@(posedge wb_clk) disable iff (wb_rst) wbs_ack |=> !wbs_ack)
      else report_problem("slave ack stayed high for two cycles in a row");

   assert property (@(posedge wb_clk) disable iff (wb_rst) !dup_write)
      else report_problem("a destination word was written twice");

   // called 1 ns after a rising edge, returns the same way
   task automatic bus_access(input logic we, input reg_idx_e idx, input logic [31:0] wdata,
                             input logic [3:0] sel, output logic [31:0] rdata,
                             output logic got_ack, output logic got_err);
      wbs_cyc   = 1'b1;
      wbs_stb   = 1'b1;
      wbs_we    = we;
      wbs_sel   = sel;
      wbs_adr   = {27'd0, idx, 2'b00};
      wbs_dat_w = wdata;
      do begin
         @(posedge wb_clk);
         #1;
      end while (!(wbs_ack || wbs_err));
      rdata   = wbs_dat_r;
      got_ack = wbs_ack;
      got_err = wbs_err;
      @(posedge wb_clk);  // strobe still high on the edge that samples ack
      #1;
      wbs_cyc = 1'b0;
      wbs_stb = 1'b0;
      wbs_we  = 1'b0;
      @(posedge wb_clk);  // idle cycle between accesses
      #1;
   endtask

   task automatic wb_write(input reg_idx_e idx, input logic [31:0] data);
      logic [31:0] rd;
      logic        got_ack;
      logic        got_err;
      bus_access(1'b1, idx, data, 4'hf, rd, got_ack, got_err);
      assert (got_ack && !got_err) else report_problem("register write not acknowledged");
   endtask

   task automatic wb_read(input reg_idx_e idx, output logic [31:0] data);
      logic got_ack;
      logic got_err;
      bus_access(1'b0, idx, '0, 4'hf, data, got_ack, got_err);
      assert (got_ack && !got_err) else report_problem("register read not acknowledged");
   endtask

   function automatic logic [31:0] fill_pattern(input int idx);
      return {16'(idx) ^ 16'hc3a5, 16'(idx)};
   endfunction

   // addresses in words, stored as byte addresses
   task automatic put_desc(input int at, input int len, input bit irq_f, input bit eol,
                           input int src, input int dst, input int next);
      logic [31:0] ctrl;
      ctrl = 32'(len);
      ctrl[DESC_IRQ_BIT] = irq_f;
      ctrl[DESC_EOL_BIT] = eol;
      tb_mem_inst.mem[at + int'(DW_CTRL)] = ctrl;
      tb_mem_inst.mem[at + int'(DW_SRC)]  = 32'(4 * src);
      tb_mem_inst.mem[at + int'(DW_DST)]  = 32'(4 * dst);
      tb_mem_inst.mem[at + int'(DW_NEXT)] = 32'(4 * next);
   endtask

   task automatic fill_src(input int src, input int len);
      for (int i = 0; i < len; i++)
         tb_mem_inst.mem[src + i] = $random(seed);
   endtask

   task automatic check_copy(input int src, input int dst, input int len);
      for (int i = 0; i < len; i++)
         expect_eq($sformatf("tb_mem_inst.mem[%0d]", dst + i),
                   tb_mem_inst.mem[src + i], tb_mem_inst.mem[dst + i]);
   endtask

   task automatic check_untouched(input int dst, input int len);
      for (int i = 0; i < len; i++)
         expect_eq($sformatf("tb_mem_inst.mem[%0d]", dst + i),
                   fill_pattern(dst + i), tb_mem_inst.mem[dst + i]);
   endtask

   // disable, clear int, load head, enable
   task automatic run_chain(input int head);
      wb_write(REG_CCR, 32'(1) << CCR_INT_CLR);
      wb_write(REG_NDAR, 32'(4 * head));
      wb_write(REG_CCR, 32'(1) << CCR_ENABLE);
   endtask

   task automatic wait_int();
      while (!irq) begin
         @(posedge wb_clk);
         #1;
      end
   endtask

   task automatic wait_idle();
      logic [31:0] csr;
      do
         wb_read(REG_CSR, csr);
      while (csr[CSR_BUSY]);
   endtask

   initial begin
      #(WATCHDOG_NS);
      report_problem("watchdog expired, the DMA engine hung");
   end

   initial begin
      logic [31:0] rd;
      logic        got_ack;
      logic        got_err;
      int          base_rises;
      wb_rst    = 1'b1;
      wbs_cyc   = 1'b0;
      wbs_stb   = 1'b0;
      wbs_we    = 1'b0;
      wbs_sel   = 4'h0;
      wbs_adr   = '0;
      wbs_dat_w = '0;
      b_slow    = 1'b0;
      repeat (2) @(posedge wb_clk);
      #1;
      wb_rst = 1'b0;
      for (int i = 0; i < `DMA_MEM_WORDS; i++)
         tb_mem_inst.mem[i] = fill_pattern(i);

      // after reset
      expect_eq("wbs_ack_o", 0, wbs_ack);
      expect_eq("wbs_err_o", 0, wbs_err);
      expect_eq("int_o", 0, irq);
      expect_eq("wbma_cyc_o", 0, wbma_cyc);
      expect_eq("wbma_stb_o", 0, wbma_stb);
      expect_eq("wbmb_cyc_o", 0, wbmb_cyc);
      expect_eq("wbmb_stb_o", 0, wbmb_stb);
      wb_read(REG_CSR, rd);
      expect_eq("CSR", 0, rd);
      wb_read(REG_CCR, rd);
      expect_eq("CCR", 0, rd);

      // register rules
      wb_write(REG_NDAR, 32'h1234_5670);
      wb_read(REG_NDAR, rd);
      expect_eq("NDAR", 32'h1234_5670, rd);
      wb_read(REG_CSR, rd);
      expect_eq("CSR ndar dirty", 1, rd[CSR_NDAR_DIRTY]);
      bus_access(1'b0, REG_CSR, '0, 4'b0011, rd, got_ack, got_err);
      expect_eq("wbs_err_o", 1, got_err);
      expect_eq("wbs_ack_o", 0, got_ack);
      wb_read(REG_RSVD, rd);
      expect_eq("RSVD", 0, rd);

      // single descriptor with interrupt
      fill_src(64, SINGLE_LEN);
      put_desc(SINGLE_DESC, SINGLE_LEN, 1'b1, 1'b1, 64, 512, 0);
      run_chain(SINGLE_DESC);
      wb_write(REG_NDAR, 32'hdead_beec);   // ignored while enabled
      wb_read(REG_NDAR, rd);
      expect_eq("NDAR", 32'(4 * SINGLE_DESC), rd);
      wait_int();
      wait_idle();
      check_copy(64, 512, SINGLE_LEN);
      wb_read(REG_SG_CTRL, rd);
      expect_eq("SG_CTRL", {2'b11, 14'd0, 16'(SINGLE_LEN)}, rd);
      wb_read(REG_SG_SRC, rd);
      expect_eq("SG_SRC", 32'(4 * 64), rd);
      wb_read(REG_SG_DST, rd);
      expect_eq("SG_DST", 32'(4 * 512), rd);
      wb_write(REG_CCR, 32'(1) << CCR_INT_CLR);
      expect_eq("int_o", 0, irq);

      // chain of three, interrupt on the last only
      for (int k = 0; k < 3; k++) begin
         chain_len[k] = int'($unsigned($random(seed)) % CHAIN_MAX) + 1;
         fill_src(96 + 32 * k, chain_len[k]);
         put_desc(CHAIN_DESC + 4 * k, chain_len[k], k == 2, k == 2,
                  96 + 32 * k, 544 + 32 * k, CHAIN_DESC + 4 * (k + 1));
      end
      base_rises = int_rises;
      run_chain(CHAIN_DESC);
      wait_int();
      // every copy must already be complete when int_o first rises
      for (int k = 0; k < 3; k++)
         check_copy(96 + 32 * k, 544 + 32 * k, chain_len[k]);
      wait_idle();
      expect_eq("int_o rising edges", 1, int_rises - base_rises);
      wb_read(REG_DAR, rd);
      expect_eq("DAR", 32'(4 * (CHAIN_DESC + 8)), rd);

      // slow port B fills the FIFO
      fill_src(192, BP_LEN);
      put_desc(BP_DESC, BP_LEN, 1'b1, 1'b1, 192, 640, 0);
      b_slow = 1'b1;
      run_chain(BP_DESC);
      wait_int();
      wait_idle();
      b_slow = 1'b0;
      check_copy(192, 640, BP_LEN);

      // pause after the first descriptor, then resume
      fill_src(256, PAUSE_LEN);
      fill_src(288, PAUSE_LEN);
      put_desc(PAUSE_DESC, PAUSE_LEN, 1'b0, 1'b0, 256, 704, PAUSE_DESC + 4);
      put_desc(PAUSE_DESC + 4, PAUSE_LEN, 1'b1, 1'b1, 288, 736, 0);
      run_chain(PAUSE_DESC);
      while (!wbma_cyc) begin
         @(posedge wb_clk);
         #1;
      end
      wb_write(REG_CCR, 32'h0);
      wait_idle();
      check_copy(256, 704, PAUSE_LEN);
      check_untouched(736, PAUSE_LEN);
      expect_eq("int_o", 0, irq);
      wb_write(REG_CCR, (32'(1) << CCR_ENABLE) | (32'(1) << CCR_RESUME));
      wait_int();
      wait_idle();
      check_copy(288, 736, PAUSE_LEN);

      $display("ALL TESTS PASSED");
      $finish;
   end

endmodule

`default_nettype wire

// ==== compile.f ====
+incdir+design
design/dma_regs_pkg.sv
design/dma_desc_pkg.sv
design/dma_regs.sv
design/sg_reader.sv
design/xfer_fifo.sv
design/sg_writer.sv
design/dma_sg_top.sv
verif/tb_mem.sv
verif/dma_sg_tb.sv
